/* compile.f */
+incdir+hw
hw/arith_op_pkg.sv
hw/arith_types_pkg.sv
hw/int_alu.sv
hw/int_mult_pipe.sv
hw/int_div_seq.sv
hw/int_div_signed.sv
hw/arith_unit.sv
test/arith_unit_properties.sv
test/arith_unit_tb.sv

/* hw/arith_macros.svh */
// Width and latency constants for the arithmetic unit, included by RTL and testbench
`ifndef ARITH_MACROS_SVH
`define ARITH_MACROS_SVH

// data path width
`define ARITH_WIDTH 32

// shift amount comes from the low bits of the right operand
`define ARITH_SHAMT_W 5

// multiplier latency in cycles, in_valid to out_valid
`define ARITH_MULT_STAGES 3

// divide iteration counter
`define ARITH_DIV_CNT_W 6

`endif

/* hw/arith_op_pkg.sv */
// Control encodings for the arithmetic unit: opcodes and top-level FSM states
package arith_op_pkg;

  // command opcodes
  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_sll  = 4'd2,
    op_srl  = 4'd3,
    op_sra  = 4'd4,
    op_slt  = 4'd5,  // signed
    op_sltu = 4'd6,
    op_seq  = 4'd7,
    op_mul  = 4'd8,  // low product word
    op_div  = 4'd9,  // signed
    op_divu = 4'd10
  } arith_op_e;

  // top-level FSM
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_mult = 2'd1,
    st_div  = 2'd2,
    st_resp = 2'd3
  } ctrl_state_e;

endpackage

/* hw/arith_types_pkg.sv */
// Data types for the arithmetic unit: data word, command and response records
`include "arith_macros.svh"

package arith_types_pkg;

  // one data word
  typedef logic [`ARITH_WIDTH-1:0] word_t;

  // command as presented on the cmd port
  typedef struct packed {
    arith_op_pkg::arith_op_e op;
    word_t                   left;
    word_t                   right;
  } arith_cmd_t;

  // response returned on the rsp port
  typedef struct packed {
    word_t data;  // alu result, product or quotient
    word_t aux;   // remainder for divides, else zero
  } arith_rsp_t;

endpackage

/* hw/arith_unit.sv */
// Arithmetic unit top level: accepts one command on valid/ready and returns one response
module arith_unit (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cmd_valid,
  input  arith_types_pkg::arith_cmd_t cmd,
  output logic                        cmd_ready,
  output logic                        rsp_valid,
  output arith_types_pkg::arith_rsp_t rsp,
  input  logic                        rsp_ready
);

  arith_op_pkg::ctrl_state_e   state;
  arith_types_pkg::arith_cmd_t cmd_q;
  arith_types_pkg::word_t      alu_result;
  logic                        mult_go;
  logic                        mult_done;
  arith_types_pkg::word_t      mult_product;
  logic                        div_go;
  logic                        div_done;
  logic                        div_is_signed;
  arith_types_pkg::word_t      div_quotient;
  arith_types_pkg::word_t      div_remainder;

  assign cmd_ready     = state == arith_op_pkg::st_idle;
  assign div_is_signed = cmd_q.op == arith_op_pkg::op_div;

  int_alu int_alu_i (
    .op     (cmd_q.op),
    .left   (cmd_q.left),
    .right  (cmd_q.right),
    .result (alu_result)
  );

  int_mult_pipe int_mult_pipe_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (mult_go),
    .left      (cmd_q.left),
    .right     (cmd_q.right),
    .out_valid (mult_done),
    .product   (mult_product)
  );

  int_div_signed int_div_signed_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (div_go),
    .is_signed (div_is_signed),
    .dividend  (cmd_q.left),
    .divisor   (cmd_q.right),
    .done      (div_done),
    .quotient  (div_quotient),
    .remainder (div_remainder)
  );

  // accepted command, payload only
  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      cmd_q <= cmd;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= arith_op_pkg::st_idle;
      mult_go   <= 1'b0;
      div_go    <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      mult_go <= 1'b0;  // single-cycle pulses
      div_go  <= 1'b0;
      case (state)
        arith_op_pkg::st_idle: begin
          if (cmd_valid) begin
            case (cmd.op)
              arith_op_pkg::op_mul: begin
                mult_go <= 1'b1;
                state   <= arith_op_pkg::st_mult;
              end
              arith_op_pkg::op_div, arith_op_pkg::op_divu: begin
                div_go <= 1'b1;
                state  <= arith_op_pkg::st_div;
              end
              default: begin
                state <= arith_op_pkg::st_resp;  // alu result taken next edge
              end
            endcase
          end
        end
        arith_op_pkg::st_mult: begin
          if (mult_done) begin
            rsp       <= '{data: mult_product, aux: '0};
            rsp_valid <= 1'b1;
            state     <= arith_op_pkg::st_resp;
          end
        end
        arith_op_pkg::st_div: begin
          if (div_done) begin
            rsp       <= '{data: div_quotient, aux: div_remainder};
            rsp_valid <= 1'b1;
            state     <= arith_op_pkg::st_resp;
          end
        end
        arith_op_pkg::st_resp: begin
          // an alu command arrives here with rsp_valid still low
          if (!rsp_valid) begin
            rsp       <= '{data: alu_result, aux: '0};
            rsp_valid <= 1'b1;
          end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
            state     <= arith_op_pkg::st_idle;
          end
        end
        default: begin
          state <= arith_op_pkg::st_idle;
        end
      endcase
    end
  end

endmodule

/* hw/int_alu.sv */
// Combinational add, subtract, shift and compare datapath used for single-cycle opcodes
`include "arith_macros.svh"

module int_alu (
  input  arith_op_pkg::arith_op_e op,
  input  arith_types_pkg::word_t  left,
  input  arith_types_pkg::word_t  right,
  output arith_types_pkg::word_t  result
);

  logic [`ARITH_SHAMT_W-1:0] shamt;
  logic                      lt_signed;
  logic                      lt_unsigned;
  logic                      equal;

  assign shamt       = right[`ARITH_SHAMT_W-1:0];  // upper bits ignored
  assign lt_signed   = $signed(left) < $signed(right);
  assign lt_unsigned = left < right;
  assign equal       = left == right;

  always_comb begin
    result = '0;
    case (op)
      arith_op_pkg::op_add: begin
        result = left + right;
      end
      arith_op_pkg::op_sub: begin
        result = left - right;
      end
      arith_op_pkg::op_sll: begin
        result = left << shamt;
      end
      arith_op_pkg::op_srl: begin
        result = left >> shamt;
      end
      arith_op_pkg::op_sra: begin
        result = $signed(left) >>> shamt;  // keeps sign bit
      end
      arith_op_pkg::op_slt: begin
        result = {{(`ARITH_WIDTH-1){1'b0}}, lt_signed};
      end
      arith_op_pkg::op_sltu: begin
        result = {{(`ARITH_WIDTH-1){1'b0}}, lt_unsigned};
      end
      arith_op_pkg::op_seq: begin
        result = {{(`ARITH_WIDTH-1){1'b0}}, equal};
      end
      default: begin
        result = '0;  // mul, div and unused codes
      end
    endcase
  end

endmodule

/* hw/int_div_seq.sv */
// Unsigned restoring divider, one quotient bit per cycle, result held until the next start
`include "arith_macros.svh"

module int_div_seq (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  arith_types_pkg::word_t dividend,
  input  arith_types_pkg::word_t divisor,
  output logic                   done,
  output arith_types_pkg::word_t quotient,
  output arith_types_pkg::word_t remainder
);

  localparam logic [`ARITH_DIV_CNT_W-1:0] last_step = `ARITH_DIV_CNT_W'(`ARITH_WIDTH - 1);

  logic                        busy;
  logic [`ARITH_DIV_CNT_W-1:0] cnt;
  arith_types_pkg::word_t      divisor_q;
  logic [`ARITH_WIDTH:0]       rem_sh;
  logic [`ARITH_WIDTH:0]       diff;

  // quotient register doubles as the dividend shifter
  assign rem_sh = {remainder, quotient[`ARITH_WIDTH-1]};
  assign diff   = rem_sh - {1'b0, divisor_q};  // msb set means borrow

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt  <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (cnt == last_step) begin
          busy <= 1'b0;
          done <= 1'b1;  // same edge as the final bit
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      quotient  <= dividend;
      remainder <= '0;
      divisor_q <= divisor;
    end else if (busy) begin
      if (diff[`ARITH_WIDTH]) begin
        remainder <= rem_sh[`ARITH_WIDTH-1:0];  // restore
      end else begin
        remainder <= diff[`ARITH_WIDTH-1:0];
      end
      quotient <= {quotient[`ARITH_WIDTH-2:0], ~diff[`ARITH_WIDTH]};
    end
  end

endmodule

/* hw/int_div_signed.sv */
// Sign and divide-by-zero handling around the unsigned divider, C truncation rules
`include "arith_macros.svh"

module int_div_signed (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  logic                   is_signed,
  input  arith_types_pkg::word_t dividend,
  input  arith_types_pkg::word_t divisor,
  output logic                   done,
  output arith_types_pkg::word_t quotient,
  output arith_types_pkg::word_t remainder
);

  logic                   dividend_neg;
  logic                   divisor_neg;
  arith_types_pkg::word_t dividend_mag;
  arith_types_pkg::word_t divisor_mag;
  arith_types_pkg::word_t core_q;
  arith_types_pkg::word_t core_r;
  logic                   neg_q;
  logic                   neg_r;
  logic                   div_zero;
  arith_types_pkg::word_t dividend_q;

  assign dividend_neg = is_signed & dividend[`ARITH_WIDTH-1];
  assign divisor_neg  = is_signed & divisor[`ARITH_WIDTH-1];
  assign dividend_mag = dividend_neg ? -dividend : dividend;  // min value maps to itself
  assign divisor_mag  = divisor_neg ? -divisor : divisor;

  // operand info kept for the whole divide
  always_ff @(posedge clk) begin
    if (start) begin
      neg_q      <= dividend_neg ^ divisor_neg;
      neg_r      <= dividend_neg;  // remainder follows dividend
      div_zero   <= divisor == '0;
      dividend_q <= dividend;
    end
  end

  int_div_seq int_div_seq_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .dividend  (dividend_mag),
    .divisor   (divisor_mag),
    .done      (done),
    .quotient  (core_q),
    .remainder (core_r)
  );

  assign quotient  = div_zero ? '1 : (neg_q ? -core_q : core_q);
  assign remainder = div_zero ? dividend_q : (neg_r ? -core_r : core_r);

endmodule

/* hw/int_mult_pipe.sv */
// Three-stage pipelined multiplier returning the low word of the product
`include "arith_macros.svh"

module int_mult_pipe (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  arith_types_pkg::word_t left,
  input  arith_types_pkg::word_t right,
  output logic                   out_valid,
  output arith_types_pkg::word_t product
);

  arith_types_pkg::word_t    left_q;
  arith_types_pkg::word_t    right_q;
  logic [2*`ARITH_WIDTH-1:0] full_q;
  logic                      valid_s1;
  logic                      valid_s2;

  // valid bits follow the data through the stages
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_s1  <= 1'b0;
      valid_s2  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      valid_s1  <= in_valid;
      valid_s2  <= valid_s1;
      out_valid <= valid_s2;
    end
  end

  always_ff @(posedge clk) begin
    left_q  <= left;   // stage 1
    right_q <= right;
    full_q  <= left_q * right_q;  // stage 2, full width
    product <= full_q[`ARITH_WIDTH-1:0];  // stage 3
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the arithmetic unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
  -f compile.f --top-module arith_unit_tb -o arith_unit_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/arith_unit_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx 'All tests passed!'; then
  exit 0
else
  echo "pass message not found in simulation output"
  exit 1
fi

/* test/arith_unit_properties.sv */
// Concurrent handshake checks for the arithmetic unit, bound into the top level
module arith_unit_properties (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        cmd_ready,
  input logic                        rsp_valid,
  input logic                        rsp_ready,
  input arith_types_pkg::arith_rsp_t rsp
);

  int unsigned fail_count = 0;  // read by the testbench at the end

  // stalled response must not move
  rsp_held: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
    else begin
      fail_count++;
      $error("rsp changed or dropped while rsp_ready was low");
    end

  no_cmd_with_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> !cmd_ready)
    else begin
      fail_count++;
      $error("cmd_ready high while a response is pending");
    end

  rsp_low_after_reset: assert property (@(posedge clk)
    !rst_n |=> !rsp_valid)
    else begin
      fail_count++;
      $error("rsp_valid high in the cycle after reset");
    end

endmodule

bind arith_unit arith_unit_properties arith_unit_properties_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .cmd_ready (cmd_ready),
  .rsp_valid (rsp_valid),
  .rsp_ready (rsp_ready),
  .rsp       (rsp)
);

/* test/arith_unit_tb.sv */
// Directed testbench for the arithmetic unit: sends commands, checks results, latency and stalls
`include "arith_macros.svh"

module arith_unit_tb;

  localparam int timeout_cycles = 20000;  // 436 commands, under 7000 cycles worst case

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic                        cmd_valid;
  arith_types_pkg::arith_cmd_t cmd;
  logic                        cmd_ready;
  logic                        rsp_valid;
  arith_types_pkg::arith_rsp_t rsp;
  logic                        rsp_ready;
  int                          seed = 13;
  int                          cycle_count;

  always #5 clk = ~clk;

  arith_unit arith_unit_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .rsp_ready (rsp_ready)
  );

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "stopping at first error");
  endtask

  // reference model, C rules for division
  function automatic arith_types_pkg::arith_rsp_t expected_rsp(input arith_op_pkg::arith_op_e op,
      input arith_types_pkg::word_t a, input arith_types_pkg::word_t b);
    arith_types_pkg::arith_rsp_t r;
    logic [`ARITH_SHAMT_W-1:0]   sh;
    logic [2*`ARITH_WIDTH-1:0]   prod;
    arith_types_pkg::word_t      ma;
    arith_types_pkg::word_t      mb;
    arith_types_pkg::word_t      q;
    arith_types_pkg::word_t      rem;
    logic                        sa;
    logic                        sb;
    r = '0;
    sh = b[`ARITH_SHAMT_W-1:0];
    sa = (op == arith_op_pkg::op_div) && a[`ARITH_WIDTH-1];
    sb = (op == arith_op_pkg::op_div) && b[`ARITH_WIDTH-1];
    case (op)
      arith_op_pkg::op_add:  r.data = a + b;
      arith_op_pkg::op_sub:  r.data = a - b;
      arith_op_pkg::op_sll:  r.data = a << sh;
      arith_op_pkg::op_srl:  r.data = a >> sh;
      arith_op_pkg::op_sra:  r.data = a[`ARITH_WIDTH-1] ? ~(~a >> sh) : (a >> sh);
      arith_op_pkg::op_slt: begin
        if (a[`ARITH_WIDTH-1] != b[`ARITH_WIDTH-1]) begin
          r.data = a[`ARITH_WIDTH-1] ? 1 : 0;  // negative left is smaller
        end else begin
          r.data = (a < b) ? 1 : 0;
        end
      end
      arith_op_pkg::op_sltu: r.data = (a < b) ? 1 : 0;
      arith_op_pkg::op_seq:  r.data = (a == b) ? 1 : 0;
      arith_op_pkg::op_mul: begin
        prod = {{`ARITH_WIDTH{1'b0}}, a} * {{`ARITH_WIDTH{1'b0}}, b};
        r.data = prod[`ARITH_WIDTH-1:0];
      end
      arith_op_pkg::op_div, arith_op_pkg::op_divu: begin
        if (b == '0) begin
          r.data = '1;
          r.aux  = a;
        end else begin
          ma = sa ? -a : a;  // magnitudes, min value stays 2^31
          mb = sb ? -b : b;
          q = ma / mb;
          rem = ma % mb;
          r.data = (sa != sb) ? -q : q;
          r.aux  = sa ? -rem : rem;
        end
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic int expected_latency(input arith_op_pkg::arith_op_e op);
    case (op)
      arith_op_pkg::op_mul:                        return `ARITH_MULT_STAGES + 1;
      arith_op_pkg::op_div, arith_op_pkg::op_divu: return `ARITH_WIDTH + 2;
      default:                                     return 1;
    endcase
  endfunction

  function automatic logic [2:0] rand_stall();
    return 3'($random(seed));
  endfunction

  task automatic check_word(input string tag, input string field,
      input arith_types_pkg::word_t expected, input arith_types_pkg::word_t actual);
    assert (actual === expected) else
      stop_on_error($sformatf("MISMATCH %s %s expected %h actual %h",
                              tag, field, expected, actual));
  endtask

  // one command through the handshake, called and returning 1 unit after an edge
  task automatic run_cmd(input string test_name, input arith_op_pkg::arith_op_e op,
      input arith_types_pkg::word_t a, input arith_types_pkg::word_t b, input logic [2:0] stall);
    arith_types_pkg::arith_rsp_t exp_rsp;
    arith_types_pkg::arith_rsp_t held;
    int                          latency;
    string                       tag;
    tag = {test_name, " ", op.name()};
    exp_rsp = expected_rsp(op, a, b);
    cmd_valid = 1'b1;
    cmd = '{op: op, left: a, right: b};
    while (!cmd_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);  // accept edge
    #1;
    cmd_valid = 1'b0;
    latency = 0;
    do begin
      @(posedge clk);
      #1;
      latency++;
    end while (!rsp_valid);
    assert (latency == expected_latency(op)) else
      stop_on_error($sformatf("MISMATCH %s latency expected %0d actual %0d",
                              tag, expected_latency(op), latency));
    held = rsp;
    assert (!cmd_ready) else
      stop_on_error($sformatf("%s: cmd_ready is high while a response is pending", tag));
    repeat (stall) begin
      @(posedge clk);
      #1;
      assert (rsp_valid && !cmd_ready && rsp == held) else
        stop_on_error($sformatf("%s: response not held while rsp_ready was low", tag));
    end
    check_word(tag, "data", exp_rsp.data, rsp.data);
    check_word(tag, "aux", exp_rsp.aux, rsp.aux);
    rsp_ready = 1'b1;
    @(posedge clk);  // consume edge
    #1;
    rsp_ready = 1'b0;
    assert (!rsp_valid && cmd_ready) else
      stop_on_error($sformatf("%s: unit did not return to idle after the response", tag));
  endtask

  task automatic measure_latency();
    run_cmd("latency", arith_op_pkg::op_add, 32'd3, 32'd4, 3'd0);
    run_cmd("latency", arith_op_pkg::op_mul, 32'd3, 32'd4, 3'd0);
    run_cmd("latency", arith_op_pkg::op_div, 32'd12, 32'd4, 3'd0);
  endtask

  task automatic sweep_alu_ops();
    arith_op_pkg::arith_op_e alu_ops [8] = '{arith_op_pkg::op_add, arith_op_pkg::op_sub,
      arith_op_pkg::op_sll, arith_op_pkg::op_srl, arith_op_pkg::op_sra,
      arith_op_pkg::op_slt, arith_op_pkg::op_sltu, arith_op_pkg::op_seq};
    arith_types_pkg::word_t corner [6] = '{32'h0, 32'hffff_ffff, 32'h8000_0000,
      32'h7fff_ffff, 32'd31, 32'd45};  // 45 checks the upper shift bits are ignored
    foreach (alu_ops[k]) begin
      foreach (corner[i]) begin
        foreach (corner[j]) begin
          run_cmd("alu_corner", alu_ops[k], corner[i], corner[j], rand_stall());
        end
      end
    end
    repeat (40) begin
      run_cmd("alu_random", alu_ops[3'($random(seed))], $random(seed), $random(seed),
              rand_stall());
    end
  endtask

  task automatic multiply_pairs();
    arith_types_pkg::word_t lhs [7] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000,
      32'h7fff_ffff, 32'hffff_fffe, 32'h1234_5678};
    arith_types_pkg::word_t rhs [7] = '{32'h1234_5678, 32'hffff_ffff, 32'hffff_ffff,
      32'h2, 32'h7fff_ffff, 32'h3, 32'h9abc_def0};
    foreach (lhs[i]) begin
      run_cmd("mul_directed", arith_op_pkg::op_mul, lhs[i], rhs[i], rand_stall());
    end
    repeat (30) begin
      run_cmd("mul_random", arith_op_pkg::op_mul, $random(seed), $random(seed), rand_stall());
    end
  endtask

  task automatic divide_pairs();
    arith_op_pkg::arith_op_e div_ops [2] = '{arith_op_pkg::op_div, arith_op_pkg::op_divu};
    arith_types_pkg::word_t lhs [9] = '{32'd7, 32'hffff_fff9, 32'd7, 32'hffff_fff9,
      32'h8000_0000, 32'h8000_0000, 32'hffff_ffff, 32'd100, 32'd3};
    arith_types_pkg::word_t rhs [9] = '{32'd2, 32'd2, 32'hffff_fffe, 32'hffff_fffe,
      32'hffff_ffff, 32'd1, 32'd1, 32'd7, 32'd10};
    foreach (div_ops[k]) begin
      foreach (lhs[i]) begin
        run_cmd("div_directed", div_ops[k], lhs[i], rhs[i], rand_stall());
      end
      repeat (20) begin
        run_cmd("div_random", div_ops[k], $random(seed), $random(seed), rand_stall());
      end
    end
  endtask

  task automatic divide_by_zero();
    arith_types_pkg::word_t lhs [5] = '{32'h0, 32'd5, 32'hffff_fffb, 32'h8000_0000, 32'h0};
    lhs[4] = $random(seed);
    foreach (lhs[i]) begin
      run_cmd("div_zero", arith_op_pkg::op_div, lhs[i], 32'h0, rand_stall());
      run_cmd("div_zero", arith_op_pkg::op_divu, lhs[i], 32'h0, rand_stall());
    end
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    stop_on_error($sformatf("timeout: run did not finish within %0d cycles", timeout_cycles));
  end

  initial begin
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    rsp_ready = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    assert (!rsp_valid && cmd_ready) else
      stop_on_error("handshake outputs not idle right after reset");
    measure_latency();
    sweep_alu_ops();
    multiply_pairs();
    divide_pairs();
    divide_by_zero();
    if (arith_unit_i.arith_unit_properties_i.fail_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      stop_on_error("bound handshake assertions reported failures");
    end
  end

endmodule
